// File: filelist.f
+incdir+source
source/keypad_pkg.sv
source/button_press_decoder.sv
source/key_map.sv
source/keypad_navigator.sv
source/key_spelling.sv
source/expression_editor.sv
source/keypad_top.sv
tb/tb_keypad_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the keypad testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_keypad_top \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

// File: tb/tb_keypad_top.sv
/* Keypad input testbench */

`timescale 1ns/1ps
`include "keypad_consts.svh"

module tb_keypad_top
    import keypad_pkg::*;
();

    // Button bits
    localparam int BTN_CENTRE = 0;
    localparam int BTN_UP     = 1;
    localparam int BTN_LEFT   = 2;
    localparam int BTN_RIGHT  = 3;
    localparam int BTN_DOWN   = 4;

    // Presses in each test from navigation to random
    localparam int PRESS_COUNT    = 10 + 20 + 25 + 41 + 52 + 300;
    localparam int TIMEOUT_CYCLES = 16 + 6 * PRESS_COUNT + 100;

    typedef struct packed {
        logic        complete;
        expression_t expr;
    } handoff_t;

    logic        clk;
    logic        reset;
    logic [4:0]  btn;
    selection_t  selection;
    expression_t expr_out;
    logic        expr_valid;
    logic        expr_complete;

    // Reference state
    selection_t  exp_sel;
    logic [7:0]  model_chars [`EXPR_DEPTH];
    int          model_len;
    handoff_t    exp_q [$];
    string       test_name;
    int          seed;
    int          cycle_count;

    // Key labels row by row; SQ and PI stand for the extended codes
    string page1_labels [20] = '{"7", "8", "9", "/", "C",
                                 "4", "5", "6", "*", "D",
                                 "1", "2", "3", "-", "+",
                                 "0", ".", "^", "SQ", "="};
    string page2_labels [9]  = '{"sin", "cos", "tan",
                                 "(", ")", "!",
                                 "ln", "PI", "e"};

    keypad_top keypad_top_i (
        .clk           (clk),
        .reset         (reset),
        .btn           (btn),
        .selection     (selection),
        .expr_out      (expr_out),
        .expr_valid    (expr_valid),
        .expr_complete (expr_complete)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // ==============================
    // Reference model
    // ==============================

    function automatic selection_t next_sel(selection_t s, int b);
        int rows;
        int cols;
        rows = (s.page == PAGE_NUMBERS) ? `PAGE1_ROWS : `PAGE2_ROWS;
        cols = (s.page == PAGE_NUMBERS) ? `PAGE1_COLS : `PAGE2_COLS;
        if (b == BTN_UP && s.row > 0) begin
            s.row = s.row - 3'd1;
        end else if (b == BTN_DOWN && int'(s.row) < rows - 1) begin
            s.row = s.row + 3'd1;
        end else if (b == BTN_LEFT) begin
            if (s.page == PAGE_FUNCTIONS && s.col == 0) begin
                s = '{page: PAGE_NUMBERS, row: 3'd0, col: 3'(`PAGE1_COLS - 1)};
            end else if (s.col > 0) begin
                s.col = s.col - 3'd1;
            end
        end else if (b == BTN_RIGHT) begin
            if (s.page == PAGE_NUMBERS && int'(s.col) == cols - 1) begin
                s = '{page: PAGE_FUNCTIONS, row: 3'd0, col: 3'd0};
            end else if (int'(s.col) < cols - 1) begin
                s.col = s.col + 3'd1;
            end
        end
        return s;
    endfunction

    function automatic string label_at(selection_t s);
        if (s.page == PAGE_NUMBERS) begin
            return page1_labels[int'(s.row) * `PAGE1_COLS + int'(s.col)];
        end
        return page2_labels[int'(s.row) * `PAGE2_COLS + int'(s.col)];
    endfunction

    // Characters that a key appends
    function automatic string key_text(string label);
        if (label == "SQ") return $sformatf("%c", `CHAR_SQRT);
        if (label == "PI") return $sformatf("%c", `CHAR_PI);
        return label;
    endfunction

    function automatic handoff_t snapshot(logic complete);
        handoff_t h;
        h = '0;
        h.complete = complete;
        h.expr.len = `LEN_W'(model_len);
        for (int i = 0; i < `EXPR_DEPTH; i++) begin
            h.expr.chars[i] = model_chars[i];
        end
        return h;
    endfunction

    function automatic void apply_label(string label);
        string text;
        if (label == "C") begin
            model_len = 0;
        end else if (label == "D") begin
            if (model_len > 0) model_len = model_len - 1;
        end else if (label == "/" || label == "*" || label == "-" || label == "+") begin
            if (model_len > 0) begin
                exp_q.push_back(snapshot(1'b0));
                model_chars[0] = label[0];  // Operator opens the next operand
                model_len = 1;
            end
        end else if (label == "=") begin
            if (model_len > 0) begin
                exp_q.push_back(snapshot(1'b1));
                model_len = 0;
            end
        end else begin
            text = key_text(label);
            if (model_len + text.len() <= `EXPR_CAPACITY) begin
                for (int i = 0; i < text.len(); i++) begin
                    model_chars[model_len + i] = text[i];
                end
                model_len = model_len + text.len();
            end
        end
    endfunction

    // ==============================
    // Stimulus
    // ==============================

    // Starts and ends on a falling edge
    task automatic press(int b);
        if (b == BTN_CENTRE) begin
            apply_label(label_at(exp_sel));
        end else begin
            exp_sel = next_sel(exp_sel, b);
        end
        btn[b] = 1'b0;
        @(negedge clk);
        btn = '1;
        repeat (5) @(negedge clk);
        check_value("selection", 32'(exp_sel), 32'(selection));
    endtask

    task automatic go_to(selection_t t);
        while (exp_sel.page != t.page) begin
            press((exp_sel.page == PAGE_FUNCTIONS) ? BTN_LEFT : BTN_RIGHT);
        end
        while (exp_sel.row > t.row) press(BTN_UP);
        while (exp_sel.row < t.row) press(BTN_DOWN);
        while (exp_sel.col > t.col) press(BTN_LEFT);
        while (exp_sel.col < t.col) press(BTN_RIGHT);
    endtask

    task automatic type_label(string label);
        selection_t target;
        bit         found;
        target = '0;
        found  = 1'b0;
        for (int i = 0; i < 20; i++) begin
            if (!found && page1_labels[i] == label) begin
                target = '{page: PAGE_NUMBERS, row: 3'(i / 5), col: 3'(i % 5)};
                found  = 1'b1;
            end
        end
        for (int i = 0; i < 9; i++) begin
            if (!found && page2_labels[i] == label) begin
                target = '{page: PAGE_FUNCTIONS, row: 3'(i / 3), col: 3'(i % 3)};
                found  = 1'b1;
            end
        end
        if (!found) begin
            $display("Key %s is not on the keypad", label);
            $display("Simulation finished: FAIL");
            $fatal(1, "unknown key");
        end
        go_to(target);
        press(BTN_CENTRE);
    endtask

    // ==============================
    // Monitor and timeout
    // ==============================

    // Outputs are settled at the falling edge
    initial begin : monitor
        handoff_t h;
        forever begin
            @(negedge clk);
            if (!reset && (expr_valid || expr_complete)) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected hand-off from the editor in test %s", test_name);
                    $display("Simulation finished: FAIL");
                    $fatal(1, "unexpected hand-off");
                end
                h = exp_q.pop_front();
                check_value("complete pulse", 32'(h.complete), 32'(expr_complete));
                check_value("valid pulse", 32'(!h.complete), 32'(expr_valid));
                check_value("length", 32'(h.expr.len), 32'(expr_out.len));
                for (int i = 0; i < int'(h.expr.len); i++) begin
                    check_value($sformatf("char %0d", i), 32'(h.expr.chars[i]),
                                32'(expr_out.chars[i]));
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles, the run did not finish", cycle_count);
                $display("Simulation finished: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    // ==============================
    // Tests
    // ==============================

    initial begin
        selection_t want;
        reset     = 1'b1;
        btn       = '1;
        seed      = 99;
        model_len = 0;
        test_name = "reset";
        exp_sel   = '{page: PAGE_NUMBERS, row: 3'd0, col: 3'd0};
        for (int i = 0; i < `EXPR_DEPTH; i++) model_chars[i] = 8'h00;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_name = "navigation";
        want = '{page: PAGE_NUMBERS, row: 3'd0, col: 3'd0};
        check_value("reset selection", 32'(want), 32'(selection));
        repeat (4) press(BTN_DOWN);
        check_value("row after four downs", 32'd3, 32'(selection.row));
        repeat (5) press(BTN_RIGHT);
        want = '{page: PAGE_FUNCTIONS, row: 3'd0, col: 3'd0};
        check_value("page 2 entry", 32'(want), 32'(selection));
        press(BTN_LEFT);
        want = '{page: PAGE_NUMBERS, row: 3'd0, col: 3'd4};
        check_value("page 1 return", 32'(want), 32'(selection));

        test_name = "operator hand-off";
        type_label("1");
        type_label("2");
        type_label("+");
        type_label("3");
        type_label("=");

        test_name = "function spellings";
        type_label("sin");
        type_label("(");
        type_label("PI");
        type_label(")");
        type_label("!");
        type_label("ln");
        type_label("e");
        type_label("=");

        test_name = "clear and delete";
        type_label("7");
        type_label("8");
        type_label("C");
        type_label("=");   // Empty so no pulse
        type_label("+");
        type_label("D");
        type_label("5");
        type_label("6");
        type_label("D");
        type_label("9");
        type_label("=");

        test_name = "capacity";
        repeat (31) type_label("1");
        type_label("2");
        type_label("tan");
        type_label("=");

        test_name = "random presses";
        repeat (300) press($unsigned($random(seed)) % 5);

        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected hand-offs never appeared", exp_q.size());
            $display("Simulation finished: FAIL");
            $fatal(1, "missing hand-offs");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: source/keypad_top.sv
/* Keypad input top */

`timescale 1ns/1ps

module keypad_top
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  btn,            // Active low, centre at bit 0
    output selection_t  selection,
    output expression_t expr_out,
    output logic        expr_valid,
    output logic        expr_complete
);

    nav_cmd_t   nav_cmd;
    key_event_t key_event;

    // Buttons to one command per cycle
    button_press_decoder button_press_decoder_i (
        .clk     (clk),
        .reset   (reset),
        .btn     (btn),
        .nav_cmd (nav_cmd)
    );

    // Cursor over the pages, key events on centre
    keypad_navigator keypad_navigator_i (
        .clk       (clk),
        .reset     (reset),
        .nav_cmd   (nav_cmd),
        .selection (selection),
        .key_event (key_event)
    );

    expression_editor expression_editor_i (
        .clk           (clk),
        .reset         (reset),
        .key_event     (key_event),
        .expr_out      (expr_out),
        .expr_valid    (expr_valid),
        .expr_complete (expr_complete)
    );

endmodule

// File: source/expression_editor.sv
/* Expression buffer editor */

`timescale 1ns/1ps
`include "keypad_consts.svh"

module expression_editor
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  key_event_t  key_event,
    output expression_t expr_out,
    output logic        expr_valid,     // Operator hand-off
    output logic        expr_complete   // Equals hand-off
);

    expression_t       buffer;
    spelling_t         spelling;
    logic [`LEN_W:0]   grown_len;  // One spare bit so the sum never wraps
    logic              fits;

    key_spelling key_spelling_i (
        .key      (key_event.key),
        .spelling (spelling)
    );

    assign grown_len = {1'b0, buffer.len} + {{(`LEN_W - 1){1'b0}}, spelling.count};
    assign fits      = (grown_len <= `EXPR_CAPACITY);

    // ==============================
    // Editing rules
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            buffer.len    <= '0;
            expr_out.len  <= '0;
            expr_valid    <= 1'b0;
            expr_complete <= 1'b0;
        end else begin
            expr_valid    <= 1'b0;
            expr_complete <= 1'b0;

            if (key_event.valid) begin
                case (key_event.key)
                    KEY_CLEAR: buffer.len <= '0;
                    KEY_DELETE: begin
                        if (buffer.len != 0) buffer.len <= buffer.len - 1'b1;
                    end
                    KEY_DIV, KEY_MUL, KEY_SUB, KEY_ADD: begin
                        if (buffer.len != 0) begin
                            expr_out        <= buffer;
                            expr_valid      <= 1'b1;
                            // Next operand starts with the operator
                            buffer.chars[0] <= spelling.chars[0];
                            buffer.len      <= `LEN_W'(1);
                        end
                    end
                    KEY_EQUALS: begin
                        if (buffer.len != 0) begin
                            expr_out      <= buffer;
                            expr_complete <= 1'b1;
                            buffer.len    <= '0;
                        end
                    end
                    default: begin
                        // Whole spelling or nothing
                        if (fits) begin
                            for (int i = 0; i < 3; i++) begin
                                if (i < spelling.count) begin
                                    buffer.chars[buffer.len[`LEN_W-2:0] + (`LEN_W - 1)'(i)]
                                        <= spelling.chars[i];
                                end
                            end
                            buffer.len <= grown_len[`LEN_W-1:0];
                        end
                    end
                endcase
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_len_in_range: assert property (@(posedge clk) disable iff (reset)
        buffer.len <= `EXPR_CAPACITY)
        else $error("expression length above capacity");

    a_single_pulse: assert property (@(posedge clk) disable iff (reset)
        !(expr_valid && expr_complete))
        else $error("valid and complete pulses overlap");

endmodule

// File: source/key_spelling.sv
/* Key to characters */

`timescale 1ns/1ps
`include "keypad_consts.svh"

module key_spelling
    import keypad_pkg::*;
(
    input  key_t      key,
    output spelling_t spelling
);

    function automatic spelling_t spell(input logic [`CHAR_W-1:0] c0,
                                        input logic [`CHAR_W-1:0] c1,
                                        input logic [`CHAR_W-1:0] c2,
                                        input logic [1:0]         n);
        spelling_t s;
        s.chars[0] = c0;
        s.chars[1] = c1;
        s.chars[2] = c2;
        s.count    = n;
        return s;
    endfunction

    always_comb begin
        case (key)
            KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9:
                spelling = spell(8'h30 + {3'b000, key}, 8'h00, 8'h00, 2'd1);  // ASCII digit
            KEY_DOT:    spelling = spell(".", 8'h00, 8'h00, 2'd1);
            KEY_POW:    spelling = spell("^", 8'h00, 8'h00, 2'd1);
            KEY_SQRT:   spelling = spell(`CHAR_SQRT, 8'h00, 8'h00, 2'd1);
            KEY_SIN:    spelling = spell("s", "i", "n", 2'd3);
            KEY_COS:    spelling = spell("c", "o", "s", 2'd3);
            KEY_TAN:    spelling = spell("t", "a", "n", 2'd3);
            KEY_LPAREN: spelling = spell("(", 8'h00, 8'h00, 2'd1);
            KEY_RPAREN: spelling = spell(")", 8'h00, 8'h00, 2'd1);
            KEY_FACT:   spelling = spell("!", 8'h00, 8'h00, 2'd1);
            KEY_LN:     spelling = spell("l", "n", 8'h00, 2'd2);
            KEY_PI:     spelling = spell(`CHAR_PI, 8'h00, 8'h00, 2'd1);
            KEY_E:      spelling = spell("e", 8'h00, 8'h00, 2'd1);
            // Operators append nothing; char 0 restarts the buffer
            KEY_DIV:    spelling = spell("/", 8'h00, 8'h00, 2'd0);
            KEY_MUL:    spelling = spell("*", 8'h00, 8'h00, 2'd0);
            KEY_SUB:    spelling = spell("-", 8'h00, 8'h00, 2'd0);
            KEY_ADD:    spelling = spell("+", 8'h00, 8'h00, 2'd0);
            default:    spelling = spell(8'h00, 8'h00, 8'h00, 2'd0);  // C, D and =
        endcase
    end

endmodule

// File: source/keypad_navigator.sv
/* Keypad selection control */

`timescale 1ns/1ps
`include "keypad_consts.svh"

module keypad_navigator
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  nav_cmd_t   nav_cmd,
    output selection_t selection,
    output key_event_t key_event
);

    logic [`POS_W-1:0] last_row;
    logic [`POS_W-1:0] last_col;
    key_t              mapped_key;

    key_map key_map_i (
        .sel (selection),
        .key (mapped_key)
    );

    // Grid edge of the page shown
    assign last_row = (selection.page == PAGE_NUMBERS) ? `POS_W'(`PAGE1_ROWS - 1)
                                                       : `POS_W'(`PAGE2_ROWS - 1);
    assign last_col = (selection.page == PAGE_NUMBERS) ? `POS_W'(`PAGE1_COLS - 1)
                                                       : `POS_W'(`PAGE2_COLS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            selection <= '{page: PAGE_NUMBERS, row: '0, col: '0};
            key_event <= '{valid: 1'b0, key: KEY_0};
        end else begin
            key_event.valid <= 1'b0;
            case (nav_cmd)
                NAV_UP: begin
                    if (selection.row != 0) selection.row <= selection.row - 1'b1;
                end
                NAV_DOWN: begin
                    if (selection.row < last_row) selection.row <= selection.row + 1'b1;
                end
                NAV_LEFT: begin
                    if (selection.page == PAGE_FUNCTIONS && selection.col == 0) begin
                        // Back to the right edge of page 1
                        selection.page <= PAGE_NUMBERS;
                        selection.row  <= '0;
                        selection.col  <= `POS_W'(`PAGE1_COLS - 1);
                    end else if (selection.col != 0) begin
                        selection.col <= selection.col - 1'b1;
                    end
                end
                NAV_RIGHT: begin
                    if (selection.page == PAGE_NUMBERS && selection.col == last_col) begin
                        selection.page <= PAGE_FUNCTIONS;
                        selection.row  <= '0;
                        selection.col  <= '0;
                    end else if (selection.col < last_col) begin
                        selection.col <= selection.col + 1'b1;
                    end
                end
                NAV_SELECT: key_event <= '{valid: 1'b1, key: mapped_key};
                default: ;
            endcase
        end
    end

    // Page wraps must land inside the new page
    a_sel_in_grid: assert property (@(posedge clk) disable iff (reset)
        selection.row <= last_row && selection.col <= last_col)
        else $error("selection outside page grid");

endmodule

// File: source/key_map.sv
/* Keypad position to key */

`timescale 1ns/1ps

module key_map
    import keypad_pkg::*;
(
    input  selection_t sel,
    output key_t       key
);

    // Row and column are one octal digit each
    always_comb begin
        key = KEY_0;
        if (sel.page == PAGE_NUMBERS) begin
            case ({sel.row, sel.col})
                6'o00:   key = KEY_7;
                6'o01:   key = KEY_8;
                6'o02:   key = KEY_9;
                6'o03:   key = KEY_DIV;
                6'o04:   key = KEY_CLEAR;
                6'o10:   key = KEY_4;
                6'o11:   key = KEY_5;
                6'o12:   key = KEY_6;
                6'o13:   key = KEY_MUL;
                6'o14:   key = KEY_DELETE;
                6'o20:   key = KEY_1;
                6'o21:   key = KEY_2;
                6'o22:   key = KEY_3;
                6'o23:   key = KEY_SUB;
                6'o24:   key = KEY_ADD;
                6'o30:   key = KEY_0;
                6'o31:   key = KEY_DOT;
                6'o32:   key = KEY_POW;
                6'o33:   key = KEY_SQRT;
                6'o34:   key = KEY_EQUALS;
                default: key = KEY_0;  // Off the grid
            endcase
        end else begin
            // Function page
            case ({sel.row, sel.col})
                6'o00:   key = KEY_SIN;
                6'o01:   key = KEY_COS;
                6'o02:   key = KEY_TAN;
                6'o10:   key = KEY_LPAREN;
                6'o11:   key = KEY_RPAREN;
                6'o12:   key = KEY_FACT;
                6'o20:   key = KEY_LN;
                6'o21:   key = KEY_PI;
                6'o22:   key = KEY_E;
                default: key = KEY_0;
            endcase
        end
    end

endmodule

// File: source/button_press_decoder.sv
/* Button press decoder */

`timescale 1ns/1ps

module button_press_decoder
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] btn,      // Active low: down, right, left, up, centre
    output nav_cmd_t   nav_cmd
);

    logic [4:0] btn_prev;
    logic [4:0] pressed;

    // High for one sample on a high to low transition
    assign pressed = ~btn & btn_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            btn_prev <= '1;  // Held buttons do not count as presses
            nav_cmd  <= NAV_NONE;
        end else begin
            btn_prev <= btn;

            // Only one command wins per cycle
            if (pressed[1]) begin
                nav_cmd <= NAV_UP;
            end else if (pressed[4]) begin
                nav_cmd <= NAV_DOWN;
            end else if (pressed[2]) begin
                nav_cmd <= NAV_LEFT;
            end else if (pressed[3]) begin
                nav_cmd <= NAV_RIGHT;
            end else if (pressed[0]) begin
                nav_cmd <= NAV_SELECT;
            end else begin
                nav_cmd <= NAV_NONE;
            end
        end
    end

endmodule

// File: source/keypad_pkg.sv
/* Keypad shared types */

`include "keypad_consts.svh"

package keypad_pkg;

    typedef enum logic {
        PAGE_NUMBERS,
        PAGE_FUNCTIONS
    } page_t;

    // One command per cycle from the buttons
    typedef enum logic [2:0] {
        NAV_NONE,
        NAV_UP,
        NAV_DOWN,
        NAV_LEFT,
        NAV_RIGHT,
        NAV_SELECT
    } nav_cmd_t;

    // Digits first so that the code equals the digit value
    typedef enum logic [4:0] {
        KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
        KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
        KEY_DOT, KEY_POW, KEY_SQRT,
        KEY_DIV, KEY_MUL, KEY_SUB, KEY_ADD,
        KEY_CLEAR, KEY_DELETE, KEY_EQUALS,
        KEY_SIN, KEY_COS, KEY_TAN,
        KEY_LPAREN, KEY_RPAREN, KEY_FACT,
        KEY_LN, KEY_PI, KEY_E
    } key_t;

    typedef struct packed {
        page_t                page;
        logic [`POS_W-1:0]    row;
        logic [`POS_W-1:0]    col;
    } selection_t;

    typedef struct packed {
        logic                 valid;
        key_t                 key;
    } key_event_t;

    // chars[0] is the first character typed
    typedef struct packed {
        logic [2:0][`CHAR_W-1:0]            chars;
        logic [1:0]                         count;
    } spelling_t;

    typedef struct packed {
        logic [`EXPR_DEPTH-1:0][`CHAR_W-1:0] chars;
        logic [`LEN_W-1:0]                   len;
    } expression_t;

endpackage

// File: source/keypad_consts.svh
/* Keypad constants */

`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// ==============================
// Expression buffer
// ==============================

`define EXPR_DEPTH      32  // Buffer slots
`define EXPR_CAPACITY   31  // Longest expression kept
`define CHAR_W          8   // One character
`define LEN_W           6   // Holds 0 to EXPR_DEPTH

// ==============================
// Key grids
// ==============================

// Numbers and operators
`define PAGE1_ROWS      4
`define PAGE1_COLS      5

// Functions
`define PAGE2_ROWS      3
`define PAGE2_COLS      3

`define POS_W           3   // Row and column width

// Extended codes of the display font
`define CHAR_SQRT       8'hFB
`define CHAR_PI         8'hE3

`endif
